//--- src/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// clocks per time tick, 50 MHz core clock gives a 1 kHz time base
`define CSR_TIME_DIV 50000

`define CSR_XLEN 32

// user counter addresses, low halves
`define CSR_ADDR_CYCLE    12'hC00
`define CSR_ADDR_TIME     12'hC01
`define CSR_ADDR_INSTRET  12'hC02

// high halves
`define CSR_ADDR_CYCLEH   12'hC80
`define CSR_ADDR_TIMEH    12'hC81
`define CSR_ADDR_INSTRETH 12'hC82

`endif

//--- src/csr_pkg.sv
`include "csr_cfg.svh"

package csr_pkg;

  // major opcode of the SYSTEM group
  typedef enum logic [6:0] {
    OPC_SYSTEM = 7'b1110011
  } csr_opcode_e;

  typedef enum logic [2:0] {
    F3_PRIV = 3'b000, // ecall, ebreak, xret
    F3_RW   = 3'b001,
    F3_RS   = 3'b010,
    F3_RC   = 3'b011,
    F3_RSV  = 3'b100,
    F3_RWI  = 3'b101,
    F3_RSI  = 3'b110,
    F3_RCI  = 3'b111
  } csr_funct3_e;

  typedef enum logic [1:0] {
    CSR_OP_WRITE = 2'd0,
    CSR_OP_SET   = 2'd1,
    CSR_OP_CLEAR = 2'd2
  } csr_op_e;

  typedef struct packed {
    logic                 vld;
    csr_op_e              op;
    logic [11:0]          addr;
    logic                 write; // low for set/clear with a zero source
    logic [`CSR_XLEN-1:0] wdata;
    logic [`CSR_XLEN-1:0] mask;
    logic [4:0]           rd;
  } csr_req_t;

  typedef struct packed {
    logic                 ack;
    logic [`CSR_XLEN-1:0] rdata;
    logic [4:0]           rd;
  } csr_rsp_t;

endpackage

//--- src/csr_decode.sv
`include "csr_cfg.svh"

module csr_decode import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instr_vld,
  input  logic [31:0]          instr,
  input  logic [`CSR_XLEN-1:0] rs1_data,
  output csr_req_t             req,
  output logic                 illegal
);

  csr_funct3_e          funct3;
  csr_op_e              op;
  logic                 is_csr;
  logic                 is_imm;
  logic [4:0]           src_idx;
  logic [`CSR_XLEN-1:0] src;
  csr_req_t             req_d;

  assign funct3  = csr_funct3_e'(instr[14:12]);
  assign src_idx = instr[19:15];  // rs1 index or uimm
  assign is_imm  = instr[14];

  // immediate forms use the zero-extended 5-bit field
  assign src = is_imm ? {{(`CSR_XLEN-5){1'b0}}, src_idx} : rs1_data;

  always_comb begin
    is_csr = 1'b1;
    op     = CSR_OP_WRITE;
    case (funct3)
      F3_RW, F3_RWI: op = CSR_OP_WRITE;
      F3_RS, F3_RSI: op = CSR_OP_SET;
      F3_RC, F3_RCI: op = CSR_OP_CLEAR;
      default:       is_csr = 1'b0;
    endcase
    if (instr[6:0] != OPC_SYSTEM) begin
      is_csr = 1'b0;
    end
  end

  always_comb begin
    req_d.vld   = instr_vld & is_csr;
    req_d.op    = op;
    req_d.addr  = instr[31:20];
    req_d.rd    = instr[11:7];
    // x0 / zero immediate turns set and clear into a pure read
    req_d.write = (op == CSR_OP_WRITE) || (src_idx != 5'd0);
    case (op)
      CSR_OP_SET: begin
        req_d.mask  = src;
        req_d.wdata = src;
      end
      CSR_OP_CLEAR: begin
        req_d.mask  = src;
        req_d.wdata = '0;
      end
      default: begin
        req_d.mask  = '1;
        req_d.wdata = src;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    req     <= req_d;
    illegal <= instr_vld & ~is_csr;
    if (rst) begin
      req.vld <= 1'b0;
      illegal <= 1'b0;
    end
  end

endmodule

//--- src/csr_file.sv
`include "csr_cfg.svh"

module csr_file import csr_pkg::*; #(
  parameter int unsigned time_div = `CSR_TIME_DIV
) (
  input  logic     clk,
  input  logic     rst,
  input  csr_req_t req,
  input  logic     alu_vld,
  input  logic     alu_retired,
  output csr_rsp_t rsp
);

  localparam int CW = 2 * `CSR_XLEN;
  localparam int XL = `CSR_XLEN;

  logic [31:0]   prescale;
  logic          time_tick;
  logic          retire;
  logic          wr_en;

  logic [CW-1:0] cycle_cnt;
  logic [CW-1:0] time_cnt;
  logic [CW-1:0] instret_cnt;
  logic [CW-1:0] cycle_d;
  logic [CW-1:0] time_d;
  logic [CW-1:0] instret_d;

  logic [XL-1:0] old_half;
  logic [XL-1:0] wr_val;

  assign time_tick = (prescale == time_div - 1);
  assign retire    = alu_vld & alu_retired;
  assign wr_en     = req.vld & req.write;

  // addressed half before this cycle's update, zero when unknown
  always_comb begin
    case (req.addr)
      `CSR_ADDR_CYCLE:    old_half = cycle_cnt[XL-1:0];
      `CSR_ADDR_CYCLEH:   old_half = cycle_cnt[CW-1:XL];
      `CSR_ADDR_TIME:     old_half = time_cnt[XL-1:0];
      `CSR_ADDR_TIMEH:    old_half = time_cnt[CW-1:XL];
      `CSR_ADDR_INSTRET:  old_half = instret_cnt[XL-1:0];
      `CSR_ADDR_INSTRETH: old_half = instret_cnt[CW-1:XL];
      default:            old_half = '0;
    endcase
  end

  // masked bits come from wdata, the rest keep the old value
  assign wr_val = (old_half & ~req.mask) | (req.wdata & req.mask);

  always_comb begin
    cycle_d   = cycle_cnt + CW'(1);
    time_d    = time_tick ? time_cnt + CW'(1) : time_cnt;
    instret_d = retire ? instret_cnt + CW'(1) : instret_cnt;

    // a write replaces only its own half, the other half keeps the count
    if (wr_en) begin
      case (req.addr)
        `CSR_ADDR_CYCLE:    cycle_d[XL-1:0]   = wr_val;
        `CSR_ADDR_CYCLEH:   cycle_d[CW-1:XL]  = wr_val;
        `CSR_ADDR_TIME:     time_d[XL-1:0]    = wr_val;
        `CSR_ADDR_TIMEH:    time_d[CW-1:XL]   = wr_val;
        `CSR_ADDR_INSTRET:  instret_d[XL-1:0] = wr_val;
        `CSR_ADDR_INSTRETH: instret_d[CW-1:XL] = wr_val;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prescale    <= '0;
      cycle_cnt   <= '0;
      time_cnt    <= '0;
      instret_cnt <= '0;
    end else begin
      prescale    <= time_tick ? '0 : prescale + 32'd1;
      cycle_cnt   <= cycle_d;
      time_cnt    <= time_d;
      instret_cnt <= instret_d;
    end
  end

  // every request is acknowledged, write or not
  always_ff @(posedge clk) begin
    rsp.ack   <= req.vld;
    rsp.rdata <= old_half;
    rsp.rd    <= req.rd;
    if (rst) begin
      rsp.ack <= 1'b0;
    end
  end

endmodule

//--- src/csr_result.sv
`include "csr_cfg.svh"

module csr_result import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  csr_rsp_t             rsp,
  input  logic                 illegal_in,
  output logic                 rd_we,
  output logic [4:0]           rd_addr,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic                 illegal
);

  logic illegal_q; // lines illegal up with the file stage

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_we     <= 1'b0;
      illegal_q <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      rd_we     <= rsp.ack & (rsp.rd != 5'd0); // no write to x0
      illegal_q <= illegal_in;
      illegal   <= illegal_q;
    end
  end

  always_ff @(posedge clk) begin
    rd_addr <= rsp.rd;
    rd_data <= rsp.rdata;
  end

endmodule

//--- src/csr_unit.sv
`include "csr_cfg.svh"

module csr_unit import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instr_vld,
  input  logic [31:0]          instr,
  input  logic [`CSR_XLEN-1:0] rs1_data,
  input  logic                 alu_vld,
  input  logic                 alu_retired,
  output logic                 rd_we,
  output logic [4:0]           rd_addr,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic                 illegal
);

  csr_req_t req;
  csr_rsp_t rsp;
  logic     dec_illegal;

  // decode -> file -> result, one register each
  csr_decode i_csr_decode (
    .clk       (clk),
    .rst       (rst),
    .instr_vld (instr_vld),
    .instr     (instr),
    .rs1_data  (rs1_data),
    .req       (req),
    .illegal   (dec_illegal)
  );

  csr_file #(
    .time_div (`CSR_TIME_DIV)
  ) i_csr_file (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .alu_vld     (alu_vld),
    .alu_retired (alu_retired),
    .rsp         (rsp)
  );

  csr_result i_csr_result (
    .clk        (clk),
    .rst        (rst),
    .rsp        (rsp),
    .illegal_in (dec_illegal),
    .rd_we      (rd_we),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .illegal    (illegal)
  );

endmodule

//--- dv/csr_unit_asserts.sv
module csr_unit_asserts import csr_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       rd_we,
  input logic [4:0] rd_addr,
  input logic       illegal,
  input csr_req_t   req,
  input csr_rsp_t   rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  // the file answers each request in the very next cycle, never otherwise
  ack_follows_req: assert property (@(posedge clk) disable iff (rst)
    rsp.ack == $past(req.vld))
    else $error("ack does not follow the request by one cycle");

  no_write_x0: assert property (@(posedge clk) disable iff (rst)
    rd_we |-> rd_addr != 5'd0)
    else $error("register write to x0");

  we_illegal_excl: assert property (@(posedge clk) disable iff (rst)
    !(rd_we && illegal))
    else $error("rd_we and illegal high together");

  outputs_in_reset: assert property (@(posedge clk)
    $past(rst) |-> !rd_we && !illegal)
    else $error("outputs not low after a reset cycle");

  strobes_in_reset: assert property (@(posedge clk)
    rst |=> !req.vld && !rsp.ack)
    else $error("request or ack strobe high after a reset cycle");

endmodule

bind csr_unit csr_unit_asserts i_csr_unit_asserts (
  .clk     (clk),
  .rst     (rst),
  .rd_we   (rd_we),
  .rd_addr (rd_addr),
  .illegal (illegal),
  .req     (req),
  .rsp     (rsp)
);

//--- dv/csr_unit_tb.sv
`include "csr_cfg.svh"

module csr_unit_tb import csr_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned time_div = `CSR_TIME_DIV;
  localparam int n_tests = 400 + 2 * time_div;

  typedef struct packed {
    logic        vld;
    logic [31:0] instr;
    logic [31:0] rs1;
  } slot_t;

  typedef struct {
    time         due;
    logic        we;
    logic        ill;
    logic        chk_rd; // rd_addr and rd_data only matter with a write
    logic [4:0]  rd;
    logic [31:0] data;
  } exp_t;

  logic        clk;
  logic        rst;
  logic        instr_vld;
  logic [31:0] instr;
  logic [31:0] rs1_data;
  logic        alu_vld;
  logic        alu_retired;
  logic        rd_we;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic        illegal;

  logic [63:0] m_cycle;
  logic [63:0] m_time;
  logic [63:0] m_instret;
  logic [31:0] m_pre;
  logic [31:0] lfsr;
  slot_t       slot_a; // captured by decode at the next edge
  slot_t       slot_b; // in the file stage at the next edge
  logic        prev_retire;
  logic        prev_rst;
  logic        rst_drv;
  logic        retire_en;
  int          errors;
  int          checks;
  exp_t        exp_q[$];

  csr_unit i_csr_unit (
    .clk         (clk),
    .rst         (rst),
    .instr_vld   (instr_vld),
    .instr       (instr),
    .rs1_data    (rs1_data),
    .alu_vld     (alu_vld),
    .alu_retired (alu_retired),
    .rd_we       (rd_we),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .illegal     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // expected counter behavior for one clock edge, returns the rd result
  function automatic exp_t ref_step(input slot_t s, input logic retire, input logic in_rst);
    exp_t        e;
    logic [2:0]  f3;
    logic [4:0]  idx;
    logic [11:0] addr;
    logic [31:0] src;
    logic [31:0] old;
    logic [31:0] nv;
    logic        is_csr;
    logic        wr;
    logic [63:0] nc;
    logic [63:0] nt;
    logic [63:0] ni;
    e.due = $time + 10;
    e.we = 1'b0;
    e.ill = 1'b0;
    e.chk_rd = 1'b0;
    e.rd = '0;
    e.data = '0;
    if (in_rst) begin
      m_cycle = '0;
      m_time = '0;
      m_instret = '0;
      m_pre = '0;
      return e;
    end
    f3 = s.instr[14:12];
    idx = s.instr[19:15];
    addr = s.instr[31:20];
    is_csr = s.vld && s.instr[6:0] == 7'h73 && f3[1:0] != 2'b00;
    src = f3[2] ? {27'd0, idx} : s.rs1;
    wr = (f3[1:0] == 2'b01) || idx != 5'd0;
    case (addr)
      `CSR_ADDR_CYCLE:    old = m_cycle[31:0];
      `CSR_ADDR_CYCLEH:   old = m_cycle[63:32];
      `CSR_ADDR_TIME:     old = m_time[31:0];
      `CSR_ADDR_TIMEH:    old = m_time[63:32];
      `CSR_ADDR_INSTRET:  old = m_instret[31:0];
      `CSR_ADDR_INSTRETH: old = m_instret[63:32];
      default:            old = '0; // unknown reads as zero
    endcase
    // csrrw replaces, csrrs sets bits, csrrc clears bits
    case (f3[1:0])
      2'b10:   nv = old | src;
      2'b11:   nv = old & ~src;
      default: nv = src;
    endcase
    nc = m_cycle + 64'd1;
    nt = (m_pre == time_div - 1) ? m_time + 64'd1 : m_time;
    ni = retire ? m_instret + 64'd1 : m_instret;
    if (is_csr && wr) begin
      case (addr)
        `CSR_ADDR_CYCLE:    nc[31:0] = nv;
        `CSR_ADDR_CYCLEH:   nc[63:32] = nv;
        `CSR_ADDR_TIME:     nt[31:0] = nv;
        `CSR_ADDR_TIMEH:    nt[63:32] = nv;
        `CSR_ADDR_INSTRET:  ni[31:0] = nv;
        `CSR_ADDR_INSTRETH: ni[63:32] = nv;
        default: ;
      endcase
    end
    m_pre = (m_pre == time_div - 1) ? 32'd0 : m_pre + 32'd1;
    m_cycle = nc;
    m_time = nt;
    m_instret = ni;
    if (is_csr) begin
      e.we = s.instr[11:7] != 5'd0;
      e.chk_rd = e.we;
      e.rd = s.instr[11:7];
      e.data = old;
    end else if (s.vld) begin
      e.ill = 1'b1;
    end
    return e;
  endfunction

  function automatic slot_t csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                      input logic [4:0] rd, input logic [4:0] idx,
                                      input logic [31:0] rs1);
    slot_t s;
    s.vld = 1'b1;
    s.instr = {addr, idx, f3, rd, 7'h73};
    s.rs1 = rs1;
    return s;
  endfunction

  function automatic logic [11:0] pick_addr(input logic [2:0] k);
    case (k)
      3'd0:    return `CSR_ADDR_CYCLE;
      3'd1:    return `CSR_ADDR_CYCLEH;
      3'd2:    return `CSR_ADDR_TIME;
      3'd3:    return `CSR_ADDR_TIMEH;
      3'd4:    return `CSR_ADDR_INSTRET;
      3'd5:    return `CSR_ADDR_INSTRETH;
      3'd6:    return 12'hC03; // unknown
      default: return 12'h300;
    endcase
  endfunction

  // one clock of stimulus, the model steps for the edge just passed
  task automatic drive(input slot_t s);
    logic a;
    logic b;
    @(negedge clk);
    exp_q.push_back(ref_step(slot_b, prev_retire, prev_rst));
    slot_b = slot_a;
    slot_a = s;
    a = retire_en ? 1'(rand_bits(1)) : 1'b0;
    b = retire_en ? 1'(rand_bits(1)) : 1'b0;
    prev_retire = a & b;
    prev_rst = rst_drv;
    rst = rst_drv;
    instr_vld = s.vld;
    instr = s.instr;
    rs1_data = s.rs1;
    alu_vld = a;
    alu_retired = b;
  endtask

  task automatic idle(input int n);
    repeat (n) drive('0);
  endtask

  task automatic read_csr(input logic [11:0] addr, input logic [4:0] rd);
    drive(csr_instr(3'b010, addr, rd, 5'd0, 32'd0));
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
    errors++;
  endtask

  always @(negedge clk) begin
    exp_t e;
    if (exp_q.size() > 0 && exp_q[0].due == $time) begin
      e = exp_q.pop_front();
      checks++;
      if (rd_we !== e.we) report_mismatch("rd_we", 32'(e.we), 32'(rd_we));
      if (illegal !== e.ill) report_mismatch("illegal", 32'(e.ill), 32'(illegal));
      if (e.chk_rd && rd_addr !== e.rd) report_mismatch("rd_addr", 32'(e.rd), 32'(rd_addr));
      if (e.chk_rd && rd_data !== e.data) report_mismatch("rd_data", e.data, rd_data);
    end
  end

  initial begin
    repeat (n_tests * 20) @(posedge clk);
    $display("timeout after %0d cycles, the test sequence did not complete", n_tests * 20);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [2:0]  f3;
    logic [4:0]  idx;
    logic [11:0] addr;
    logic [2:0]  k;
    rst = 1'b1;
    instr_vld = 1'b0;
    instr = '0;
    rs1_data = '0;
    alu_vld = 1'b0;
    alu_retired = 1'b0;
    lfsr = 32'h1bc;
    m_cycle = '0;
    m_time = '0;
    m_instret = '0;
    m_pre = '0;
    slot_a = '0;
    slot_b = '0;
    prev_retire = 1'b0;
    prev_rst = 1'b1;
    rst_drv = 1'b1;
    retire_en = 1'b0;
    errors = 0;
    checks = 0;
    idle(2);
    rst_drv = 1'b0;

    // counters straight after reset
    idle(4);
    for (int i = 0; i < 6; i++) read_csr(pick_addr(i[2:0]), 5'(i + 1));

    // csrrw on every half then read back
    for (int i = 0; i < 6; i++) begin
      drive(csr_instr(3'b001, pick_addr(i[2:0]), 5'd7, 5'd3, rand_bits(32)));
      idle(2);
      read_csr(pick_addr(i[2:0]), 5'd8);
    end
    drive(csr_instr(3'b001, `CSR_ADDR_CYCLE, 5'd9, 5'd5, 32'hffff_fff0));
    idle(20); // low half wraps into the high half
    read_csr(`CSR_ADDR_CYCLEH, 5'd10);
    read_csr(`CSR_ADDR_CYCLE, 5'd11);

    // time base ticks twice
    idle(2 * time_div);
    read_csr(`CSR_ADDR_TIME, 5'd15);
    read_csr(`CSR_ADDR_TIMEH, 5'd16);

    // set and clear with random masks, sometimes a zero source
    repeat (40) begin
      f3 = {1'(rand_bits(1)), 1'b1, 1'(rand_bits(1))};
      idx = (rand_bits(2) == 0) ? 5'd0 : 5'(rand_bits(5));
      addr = pick_addr(3'(rand_bits(3) % 6));
      drive(csr_instr(f3, addr, 5'(rand_bits(5)), idx,
                      (idx == 0) ? 32'd0 : rand_bits(32)));
      read_csr(addr, 5'd12);
    end

    // random retire strobes
    retire_en = 1'b1;
    idle(30);
    read_csr(`CSR_ADDR_INSTRET, 5'd13);
    read_csr(`CSR_ADDR_INSTRETH, 5'd14);

    // back to back mix with x0, unknown addresses and illegal encodings
    repeat (200) begin
      k = 3'(rand_bits(3));
      if (k < 3'd5) begin
        f3 = 3'(rand_bits(3));
        if (f3[1:0] == 2'b00) f3[1:0] = 2'b10;
        idx = 5'(rand_bits(5));
        drive(csr_instr(f3, pick_addr(3'(rand_bits(3))), 5'(rand_bits(5)), idx,
                        (idx == 0) ? 32'd0 : rand_bits(32)));
      end else if (k == 3'd5) begin
        drive('{vld: 1'b1, instr: {25'(rand_bits(25)), 7'h33}, rs1: rand_bits(32)});
      end else if (k == 3'd6) begin
        drive('{vld: 1'b1, instr: {17'(rand_bits(17)), 1'(rand_bits(1)), 2'b00, 12'h073},
                rs1: 32'd0});
      end else begin
        idle(1);
      end
    end
    retire_en = 1'b0;
    idle(5);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- csr_unit.f
+incdir+src
src/csr_pkg.sv
src/csr_decode.sv
src/csr_file.sv
src/csr_result.sv
src/csr_unit.sv
dv/csr_unit_asserts.sv
dv/csr_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FLIST     ?= csr_unit.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --assert --timing -j $(JOBS)
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
